//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mc_mem_edge
FILELIST  = mc_mem_edge.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- hw/dma_burst_engine.sv
`timescale 1ns/1ps

module dma_burst_engine (
  input  logic                                 clk_i
  , input  logic                               rst_n_i
  , input  logic                               edge_rst_i

  , input  mc_mem_edge_pkg::burst_cmd_t        cmd_i
  , input  logic                               cmd_v_i
  , output logic                               cmd_take_o

  , input  logic [mc_mem_edge_pkg::DATA_W-1:0] wdata_i
  , input  logic                               wdata_v_i
  , output logic                               wdata_ready_o

  , output logic [mc_mem_edge_pkg::DATA_W-1:0] rdata_o
  , output logic                               rdata_v_o
  , input  logic                               rdata_yumi_i

  , output mc_mem_edge_pkg::mem_req_t          mem_req_o
  , output logic                               mem_req_v_o
  , input  logic [mc_mem_edge_pkg::DATA_W-1:0] mem_rdata_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ
  } state_e;

  state_e                               state_q;
  logic [mc_mem_edge_pkg::BEAT_W-1:0]   beat_q;
  logic [mc_mem_edge_pkg::BEAT_W-1:0]   rd_beat;
  logic [mc_mem_edge_pkg::MEM_AW-1:0]   base_q;
  logic                                 rdata_v_q;
  logic                                 last_beat;
  logic                                 wr_fire;
  logic                                 rd_yumi;
  logic                                 rd_issue;

  assign last_beat = (beat_q == mc_mem_edge_pkg::BEAT_W'(mc_mem_edge_pkg::BURST_LEN - 1));

  assign cmd_take_o    = (state_q == ST_IDLE) & cmd_v_i & ~edge_rst_i;
  assign wdata_ready_o = (state_q == ST_WRITE);
  assign wr_fire       = wdata_ready_o & wdata_v_i;
  assign rd_yumi       = rdata_v_q & rdata_yumi_i;

  // first read on entry, then the next one in each yumi cycle
  assign rd_issue = (state_q == ST_READ) & (~rdata_v_q | (rd_yumi & ~last_beat));
  assign rd_beat  = rdata_v_q ? beat_q + 1'b1 : beat_q;

  always_comb begin
    mem_req_o.wdata = wdata_i;
    if (state_q == ST_WRITE) begin
      mem_req_o.we   = 1'b1;
      mem_req_o.addr = base_q + mc_mem_edge_pkg::MEM_AW'(beat_q);
    end else begin
      mem_req_o.we   = 1'b0;
      mem_req_o.addr = base_q + mc_mem_edge_pkg::MEM_AW'(rd_beat);
    end
  end

  assign mem_req_v_o = wr_fire | rd_issue;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      beat_q    <= '0;
      rdata_v_q <= 1'b0;
    end else if (edge_rst_i) begin
      state_q   <= ST_IDLE;
      beat_q    <= '0;
      rdata_v_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (cmd_take_o) begin
            state_q <= cmd_i.write ? ST_WRITE : ST_READ;
            beat_q  <= '0;
          end
        end
        ST_WRITE: begin
          if (wr_fire) begin
            beat_q <= last_beat ? '0 : beat_q + 1'b1;
            if (last_beat) begin
              state_q <= ST_IDLE;
            end
          end
        end
        ST_READ: begin
          // store data shows up one cycle after the issue
          if (rd_issue) begin
            rdata_v_q <= 1'b1;
          end else if (rd_yumi) begin
            rdata_v_q <= 1'b0;
          end
          if (rd_yumi) begin
            beat_q <= last_beat ? '0 : beat_q + 1'b1;
            if (last_beat) begin
              state_q <= ST_IDLE;
            end
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_take_o) begin
      base_q <= cmd_i.base;
    end
  end

  // store read register only moves on a new read, so it holds while stalled
  assign rdata_o   = mem_rdata_i;
  assign rdata_v_o = rdata_v_q;

endmodule

//--- hw/dma_req_intake.sv
`timescale 1ns/1ps

module dma_req_intake (
  input  logic                               clk_i
  , input  logic                             rst_n_i
  , input  logic                             cfg_done_i

  , input  mc_mem_edge_pkg::dma_pkt_t        pkt_i
  , input  logic                             pkt_v_i
  , input  logic [mc_mem_edge_pkg::CORD_W-1:0] src_cord_i
  , output logic                             pkt_yumi_o

  , output mc_mem_edge_pkg::burst_cmd_t      cmd_o
  , output logic                             cmd_v_o
  , input  logic                             cmd_take_i

  , output logic                             edge_rst_o
);

  logic [mc_mem_edge_pkg::RESET_DEPTH-1:0] rst_chain_q;
  logic [mc_mem_edge_pkg::VC_SEL_W-1:0]    vc_sel;
  logic [mc_mem_edge_pkg::SLICE_W-1:0]     word_idx;
  logic [mc_mem_edge_pkg::MEM_AW-1:0]      block_start;
  mc_mem_edge_pkg::burst_cmd_t             cmd_q;
  logic                                    cmd_v_q;

  // edge held in reset until cfg done has walked through the chain
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_chain_q <= '1;
    end else begin
      rst_chain_q <= {rst_chain_q[mc_mem_edge_pkg::RESET_DEPTH-2:0], ~cfg_done_i};
    end
  end

  assign edge_rst_o = rst_chain_q[mc_mem_edge_pkg::RESET_DEPTH-1];

  // slice select from coordinate, word index from byte address
  assign vc_sel   = src_cord_i[mc_mem_edge_pkg::RUCHE_SEL_W +: mc_mem_edge_pkg::VC_SEL_W];
  assign word_idx = pkt_i.addr[2 +: mc_mem_edge_pkg::SLICE_W];

  // align down to the first beat of the block
  assign block_start = {vc_sel,
                        word_idx[mc_mem_edge_pkg::SLICE_W-1:mc_mem_edge_pkg::BEAT_W],
                        {mc_mem_edge_pkg::BEAT_W{1'b0}}};

  // one command slot, accept only when it is empty
  assign pkt_yumi_o = pkt_v_i & ~cmd_v_q & ~edge_rst_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cmd_v_q <= 1'b0;
    end else if (edge_rst_o) begin
      cmd_v_q <= 1'b0;
    end else if (pkt_yumi_o) begin
      cmd_v_q <= 1'b1;
    end else if (cmd_take_i) begin
      cmd_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pkt_yumi_o) begin
      cmd_q.write <= pkt_i.write_not_read;
      cmd_q.base  <= block_start;
    end
  end

  assign cmd_o   = cmd_q;
  assign cmd_v_o = cmd_v_q;

endmodule

//--- hw/mc_mem_edge.sv
`timescale 1ns/1ps

module mc_mem_edge (
  input  logic                                 clk_i
  , input  logic                               rst_n_i
  , input  logic                               cfg_done_i
  , output logic                               edge_ready_o

  , input  mc_mem_edge_pkg::dma_pkt_t          dma_pkt_i
  , input  logic                               dma_pkt_v_i
  , input  logic [mc_mem_edge_pkg::CORD_W-1:0] dma_src_cord_i
  , output logic                               dma_pkt_yumi_o

  , input  logic [mc_mem_edge_pkg::DATA_W-1:0] dma_data_i
  , input  logic                               dma_data_v_i
  , output logic                               dma_data_ready_and_o

  , output logic [mc_mem_edge_pkg::DATA_W-1:0] dma_data_o
  , output logic                               dma_data_v_o
  , input  logic                               dma_data_yumi_i
);

  mc_mem_edge_pkg::burst_cmd_t        cmd;
  logic                               cmd_v;
  logic                               cmd_take;
  logic                               edge_rst;
  mc_mem_edge_pkg::mem_req_t          mem_req;
  logic                               mem_req_v;
  logic [mc_mem_edge_pkg::DATA_W-1:0] rd_data;

  dma_req_intake intake (
    .clk_i       (clk_i)
    ,.rst_n_i    (rst_n_i)
    ,.cfg_done_i (cfg_done_i)
    ,.pkt_i      (dma_pkt_i)
    ,.pkt_v_i    (dma_pkt_v_i)
    ,.src_cord_i (dma_src_cord_i)
    ,.pkt_yumi_o (dma_pkt_yumi_o)
    ,.cmd_o      (cmd)
    ,.cmd_v_o    (cmd_v)
    ,.cmd_take_i (cmd_take)
    ,.edge_rst_o (edge_rst)
  );

  assign edge_ready_o = ~edge_rst;

  dma_burst_engine engine (
    .clk_i          (clk_i)
    ,.rst_n_i       (rst_n_i)
    ,.edge_rst_i    (edge_rst)
    ,.cmd_i         (cmd)
    ,.cmd_v_i       (cmd_v)
    ,.cmd_take_o    (cmd_take)
    ,.wdata_i       (dma_data_i)
    ,.wdata_v_i     (dma_data_v_i)
    ,.wdata_ready_o (dma_data_ready_and_o)
    ,.rdata_o       (dma_data_o)
    ,.rdata_v_o     (dma_data_v_o)
    ,.rdata_yumi_i  (dma_data_yumi_i)
    ,.mem_req_o     (mem_req)
    ,.mem_req_v_o   (mem_req_v)
    ,.mem_rdata_i   (rd_data)
  );

  mem_store store (
    .clk_i    (clk_i)
    ,.req_i   (mem_req)
    ,.req_v_i (mem_req_v)
    ,.rdata_o (rd_data)
  );

endmodule

//--- hw/mc_mem_edge_pkg.sv
package mc_mem_edge_pkg;

  // data path
  localparam int DATA_W = 32;
  localparam int ADDR_W = 30;

  // source coordinate, vcache index sits just above the ruche bit
  localparam int CORD_W      = 8;
  localparam int RUCHE_SEL_W = 1;
  localparam int NUM_VC      = 4;
  localparam int VC_SEL_W    = $clog2(NUM_VC);

  // block geometry
  localparam int BURST_LEN = 4;
  localparam int BEAT_W    = $clog2(BURST_LEN);

  // backing store, one slice per vcache
  localparam int SLICE_WORDS = 64;
  localparam int SLICE_W     = $clog2(SLICE_WORDS);
  localparam int MEM_WORDS   = NUM_VC * SLICE_WORDS;
  localparam int MEM_AW      = VC_SEL_W + SLICE_W;

  // release flops after cfg done
  localparam int RESET_DEPTH = 3;

  // incoming vcache dma packet
  typedef struct packed {
    logic              write_not_read;
    logic [ADDR_W-1:0] addr;
  } dma_pkt_t;

  // remapped block start word, intake to engine
  typedef struct packed {
    logic              write;
    logic [MEM_AW-1:0] base;
  } burst_cmd_t;

  // one store access
  typedef struct packed {
    logic              we;
    logic [MEM_AW-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

endpackage

//--- hw/mem_store.sv
`timescale 1ns/1ps

module mem_store (
  input  logic                                 clk_i
  , input  mc_mem_edge_pkg::mem_req_t          req_i
  , input  logic                               req_v_i
  , output logic [mc_mem_edge_pkg::DATA_W-1:0] rdata_o
);

  logic [mc_mem_edge_pkg::DATA_W-1:0] mem [mc_mem_edge_pkg::MEM_WORDS];
  logic [mc_mem_edge_pkg::DATA_W-1:0] rdata_q;

  // single port, a write leaves the read register alone
  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      if (req_i.we) begin
        mem[req_i.addr] <= req_i.wdata;
      end else begin
        rdata_q <= mem[req_i.addr];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- mc_mem_edge.f
hw/mc_mem_edge_pkg.sv
hw/dma_req_intake.sv
hw/dma_burst_engine.sv
hw/mem_store.sv
hw/mc_mem_edge.sv
verification/mc_mem_edge_asserts.sv
verification/tb_mc_mem_edge.sv

//--- verification/mc_mem_edge_asserts.sv
`timescale 1ns/1ps

module mc_mem_edge_asserts (
  input  logic                                 clk_i
  , input  logic                               rst_n_i
  , input  logic                               edge_ready_o
  , input  logic                               dma_pkt_yumi_o
  , input  logic [mc_mem_edge_pkg::DATA_W-1:0] dma_data_o
  , input  logic                               dma_data_v_o
  , input  logic                               dma_data_yumi_i
);

  // yumi only alongside valid
  data_yumi_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dma_data_yumi_i |-> dma_data_v_o)
    else $error("read data yumi without read data valid");

  // stalled read beat holds its value
  data_held_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (dma_data_v_o && !dma_data_yumi_i && edge_ready_o) |=> (dma_data_v_o && $stable(dma_data_o)))
    else $error("read data changed or dropped while waiting for yumi");

  pkt_yumi_out_of_reset: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dma_pkt_yumi_o |-> edge_ready_o)
    else $error("packet accepted while edge held in reset");

endmodule

bind mc_mem_edge mc_mem_edge_asserts edge_asserts (
  .clk_i            (clk_i)
  ,.rst_n_i         (rst_n_i)
  ,.edge_ready_o    (edge_ready_o)
  ,.dma_pkt_yumi_o  (dma_pkt_yumi_o)
  ,.dma_data_o      (dma_data_o)
  ,.dma_data_v_o    (dma_data_v_o)
  ,.dma_data_yumi_i (dma_data_yumi_i)
);

//--- verification/tb_mc_mem_edge.sv
`timescale 1ns/1ps

module tb_mc_mem_edge;

  typedef logic [mc_mem_edge_pkg::ADDR_W-1:0] addr_t;
  typedef logic [mc_mem_edge_pkg::CORD_W-1:0] cord_t;
  typedef logic [mc_mem_edge_pkg::DATA_W-1:0] word_t;
  typedef logic [mc_mem_edge_pkg::MEM_AW-1:0] maddr_t;

  localparam int CLK_HALF_NS   = 2;
  localparam int RESET_CYCLES  = 10;
  localparam int MAX_CFG_DELAY = 16;
  localparam int NUM_RANDOM    = 60;
  // reset release, slice isolation and address wrap
  localparam int NUM_DIRECTED  = 11;
  localparam int TXN_CYCLES    = 200;
  localparam int WATCHDOG_CYCLES =
    RESET_CYCLES + MAX_CFG_DELAY + TXN_CYCLES * (NUM_RANDOM + NUM_DIRECTED);
  localparam logic [31:0] LFSR_SEED = 32'hd2f40d6c;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      cfg_done_i;
  logic                      edge_ready_o;
  mc_mem_edge_pkg::dma_pkt_t dma_pkt_i;
  logic                      dma_pkt_v_i;
  cord_t                     dma_src_cord_i;
  logic                      dma_pkt_yumi_o;
  word_t                     dma_data_i;
  logic                      dma_data_v_i;
  logic                      dma_data_ready_and_o;
  word_t                     dma_data_o;
  logic                      dma_data_v_o;
  logic                      dma_data_yumi_i;

  logic [31:0]                             lfsr_q;
  word_t                                   model_mem [mc_mem_edge_pkg::MEM_WORDS];
  logic [mc_mem_edge_pkg::MEM_WORDS-1:0]   model_valid;
  addr_t                                   hist_addr [$];
  cord_t                                   hist_cord [$];
  int                                      error_count;
  int                                      check_count;

  mc_mem_edge uut (
    .clk_i                 (clk_i)
    ,.rst_n_i              (rst_n_i)
    ,.cfg_done_i           (cfg_done_i)
    ,.edge_ready_o         (edge_ready_o)
    ,.dma_pkt_i            (dma_pkt_i)
    ,.dma_pkt_v_i          (dma_pkt_v_i)
    ,.dma_src_cord_i       (dma_src_cord_i)
    ,.dma_pkt_yumi_o       (dma_pkt_yumi_o)
    ,.dma_data_i           (dma_data_i)
    ,.dma_data_v_i         (dma_data_v_i)
    ,.dma_data_ready_and_o (dma_data_ready_and_o)
    ,.dma_data_o           (dma_data_o)
    ,.dma_data_v_o         (dma_data_v_o)
    ,.dma_data_yumi_i      (dma_data_yumi_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF_NS clk_i = ~clk_i;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // slice from the coordinate and word aligned down to the block
  function automatic maddr_t block_word(input addr_t addr, input cord_t cord);
    int vc;
    int word;
    vc   = int'(cord >> mc_mem_edge_pkg::RUCHE_SEL_W) % mc_mem_edge_pkg::NUM_VC;
    word = int'(addr >> 2) % mc_mem_edge_pkg::SLICE_WORDS;
    word = word - (word % mc_mem_edge_pkg::BURST_LEN);
    return maddr_t'(vc * mc_mem_edge_pkg::SLICE_WORDS + word);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] t=%0t %s expected %h actual %h (errors %0d)",
               $time, name, expected, actual, error_count);
    end
  endtask

  // hold the packet until the edge takes it
  task automatic send_packet(input logic write, input addr_t addr, input cord_t cord);
    dma_pkt_i.write_not_read = write;
    dma_pkt_i.addr           = addr;
    dma_src_cord_i           = cord;
    dma_pkt_v_i              = 1'b1;
    #1;
    while (!dma_pkt_yumi_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    dma_pkt_v_i = 1'b0;
  endtask

  task automatic write_block(input addr_t addr, input cord_t cord);
    maddr_t base;
    word_t  word;
    int     beat;
    base = block_word(addr, cord);
    send_packet(1'b1, addr, cord);
    for (beat = 0; beat < mc_mem_edge_pkg::BURST_LEN; beat++) begin
      repeat (int'(rand_bits(2))) @(negedge clk_i);
      word         = rand_bits(mc_mem_edge_pkg::DATA_W);
      dma_data_i   = word;
      dma_data_v_i = 1'b1;
      #1;
      while (!dma_data_ready_and_o) begin
        @(negedge clk_i);
        #1;
      end
      @(negedge clk_i);
      dma_data_v_i = 1'b0;
      model_mem[base + maddr_t'(beat)]   = word;
      model_valid[base + maddr_t'(beat)] = 1'b1;
    end
    hist_addr.push_back(addr);
    hist_cord.push_back(cord);
  endtask

  task automatic read_block(input addr_t addr, input cord_t cord, input logic stall);
    maddr_t base;
    maddr_t idx;
    word_t  held;
    int     beat;
    logic   waiting;
    logic   take;
    base    = block_word(addr, cord);
    beat    = 0;
    waiting = 1'b0;
    held    = '0;
    send_packet(1'b0, addr, cord);
    while (beat < mc_mem_edge_pkg::BURST_LEN) begin
      take = 1'b0;
      if (dma_data_v_o) begin
        take = stall ? (rand_bits(1) != 32'd0) : 1'b1;
        if (waiting) begin
          check_value("dma_data_o held", held, dma_data_o);
        end
        if (take) begin
          idx = base + maddr_t'(beat);
          // words never written are not compared
          if (model_valid[idx]) begin
            check_value("dma_data_o", model_mem[idx], dma_data_o);
          end
          beat++;
        end
        held    = dma_data_o;
        waiting = ~take;
      end else if (waiting) begin
        error_count++;
        $display("read data valid dropped at %0t before the beat was taken", $time);
        waiting = 1'b0;
      end
      dma_data_yumi_i = take;
      @(negedge clk_i);
    end
    dma_data_yumi_i = 1'b0;
  endtask

  task automatic reset_release_test();
    int delay;
    int i;
    // packet offered while the edge is still held
    dma_pkt_i.write_not_read = 1'b1;
    dma_pkt_i.addr           = addr_t'(rand_bits(mc_mem_edge_pkg::ADDR_W));
    dma_pkt_v_i              = 1'b1;
    delay = 1 + int'(rand_bits(4));
    repeat (delay) begin
      @(negedge clk_i);
      check_value("edge_ready_o", 32'd0, 32'(edge_ready_o));
      check_value("dma_pkt_yumi_o", 32'd0, 32'(dma_pkt_yumi_o));
      check_value("dma_data_ready_and_o", 32'd0, 32'(dma_data_ready_and_o));
      check_value("dma_data_v_o", 32'd0, 32'(dma_data_v_o));
    end
    cfg_done_i = 1'b1;
    for (i = 1; i <= mc_mem_edge_pkg::RESET_DEPTH; i++) begin
      @(negedge clk_i);
      check_value("edge_ready_o", 32'(i == mc_mem_edge_pkg::RESET_DEPTH), 32'(edge_ready_o));
      if (i < mc_mem_edge_pkg::RESET_DEPTH) begin
        check_value("dma_pkt_yumi_o", 32'd0, 32'(dma_pkt_yumi_o));
      end
    end
    dma_pkt_v_i = 1'b0;
  endtask

  task automatic slice_isolation_test();
    addr_t addr;
    cord_t cord_a;
    cord_t cord_b;
    cord_t cord_c;
    addr   = addr_t'(rand_bits(mc_mem_edge_pkg::ADDR_W));
    cord_a = cord_t'(rand_bits(mc_mem_edge_pkg::CORD_W));
    cord_b = cord_a;
    cord_b[mc_mem_edge_pkg::RUCHE_SEL_W +: mc_mem_edge_pkg::VC_SEL_W] =
      cord_a[mc_mem_edge_pkg::RUCHE_SEL_W +: mc_mem_edge_pkg::VC_SEL_W] + 1'b1;
    // flipping the ruche bit keeps the slice of cord_a
    cord_c = cord_a ^ cord_t'(1);
    write_block(addr, cord_a);
    write_block(addr, cord_b);
    read_block(addr, cord_a, 1'b0);
    read_block(addr, cord_b, 1'b0);
    write_block(addr, cord_c);
    read_block(addr, cord_a, 1'b0);
    read_block(addr, cord_b, 1'b0);
  endtask

  task automatic address_wrap_test();
    addr_t addr;
    addr_t other;
    cord_t cord;
    addr = addr_t'(rand_bits(mc_mem_edge_pkg::ADDR_W));
    cord = cord_t'(rand_bits(mc_mem_edge_pkg::CORD_W));
    write_block(addr, cord);
    other = addr ^ (addr_t'(rand_bits(mc_mem_edge_pkg::ADDR_W)) << (2 + mc_mem_edge_pkg::SLICE_W));
    read_block(other, cord, 1'b0);
    // random byte offset and a beat offset that always moves
    other = addr ^ addr_t'((rand_bits(mc_mem_edge_pkg::BEAT_W) | 32'd1) << 2);
    other = other ^ addr_t'(rand_bits(2));
    read_block(other, cord, 1'b1);
  endtask

  task automatic run_random();
    int    n;
    int    pick;
    addr_t addr;
    cord_t cord;
    logic  stall;
    for (n = 0; n < NUM_RANDOM; n++) begin
      stall = (rand_bits(1) != 32'd0);
      addr  = addr_t'(rand_bits(mc_mem_edge_pkg::ADDR_W));
      cord  = cord_t'(rand_bits(mc_mem_edge_pkg::CORD_W));
      if (rand_bits(1) != 32'd0) begin
        write_block(addr, cord);
      end else begin
        // mostly revisit a written block and sometimes a fresh one
        if (rand_bits(2) != 32'd0) begin
          pick = int'(rand_bits(8)) % hist_addr.size();
          addr = hist_addr[pick];
          cord = hist_cord[pick];
        end
        read_block(addr, cord, stall);
      end
    end
  endtask

  initial begin
    rst_n_i         = 1'b0;
    cfg_done_i      = 1'b0;
    dma_pkt_i       = '0;
    dma_pkt_v_i     = 1'b0;
    dma_src_cord_i  = '0;
    dma_data_i      = '0;
    dma_data_v_i    = 1'b0;
    dma_data_yumi_i = 1'b0;
    lfsr_q          = LFSR_SEED;
    model_valid     = '0;
    error_count     = 0;
    check_count     = 0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    check_value("edge_ready_o", 32'd0, 32'(edge_ready_o));
    rst_n_i = 1'b1;
    reset_release_test();
    slice_isolation_test();
    address_wrap_test();
    run_random();
    repeat (4) @(negedge clk_i);
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
